// ==== vlog.f ====
+incdir+source
source/udma_cfg_pkg.sv
source/udma_evt_pkg.sv
source/udma_cfg_decode.sv
source/udma_ctrl.sv
source/udma_periph_cfg.sv
source/udma_cfg_resp.sv
source/udma_subsystem.sv
verif/udma_subsystem_assert.sv
verif/udma_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: udma_subsystem

export_include_dirs:
  - source

sources:
  - files:
      - source/udma_cfg_pkg.sv
      - source/udma_evt_pkg.sv
      - source/udma_cfg_decode.sv
      - source/udma_ctrl.sv
      - source/udma_periph_cfg.sv
      - source/udma_cfg_resp.sv
      - source/udma_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/udma_subsystem_assert.sv
      - verif/udma_subsystem_tb.sv

// ==== verif/udma_subsystem_tb.sv ====
// ==================================================
// testbench: clock, reset, lcg stimulus, register and event model, checks
// ==================================================

`timescale 1ns/1ps

`include "udma_params.svh"

module udma_subsystem_tb;

    localparam int NP = `UDMA_N_PERIPHS;
    localparam int NT = `UDMA_N_TRIGGERS;
    localparam int EW = `UDMA_N_EVT_SLOTS * `UDMA_N_TRIGGERS;
    localparam int TIMEOUT_CYCLES = 16;

    logic                            sys_clk = 1'b0;
    logic                            reset;
    logic [`UDMA_APB_ADDR_WIDTH-1:0] apb_paddr;
    udma_cfg_pkg::cfg_word_t         apb_pwdata;
    logic                            apb_pwrite;
    logic                            apb_psel;
    logic                            apb_penable;
    udma_cfg_pkg::cfg_word_t         apb_prdata;
    logic                            apb_pready;
    logic                            apb_pslverr;
    logic                            event_valid;
    udma_evt_pkg::evt_byte_t         event_data;
    logic                            event_ready;
    logic [EW-1:0]                   events;

    // reference model state
    udma_cfg_pkg::cfg_word_t m_cfg [NP][3];
    udma_evt_pkg::udma_evt_t m_evt_en [NP];
    logic [NP-1:0]           m_cg;
    udma_evt_pkg::evt_byte_t m_sel [NT];

    logic [31:0] seed = 32'h4e3e_2128;
    int          errors = 0;
    int          checks = 0;

    udma_subsystem dut (
        .sys_clk_i     ( sys_clk     ),
        .reset_i       ( reset       ),
        .apb_paddr_i   ( apb_paddr   ),
        .apb_pwdata_i  ( apb_pwdata  ),
        .apb_pwrite_i  ( apb_pwrite  ),
        .apb_psel_i    ( apb_psel    ),
        .apb_penable_i ( apb_penable ),
        .apb_prdata_o  ( apb_prdata  ),
        .apb_pready_o  ( apb_pready  ),
        .apb_pslverr_o ( apb_pslverr ),
        .event_valid_i ( event_valid ),
        .event_data_i  ( event_data  ),
        .event_ready_o ( event_ready ),
        .events_o      ( events      )
    );

    always #5 sys_clk = ~sys_clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // expected read word for a slot and register index
    function automatic udma_cfg_pkg::cfg_word_t model_read(int slot, int idx);
        udma_cfg_pkg::cfg_word_t word;
        word = '0;
        if (slot < NP && m_cg[slot]) begin
            case (idx)
                0, 1, 2: word = m_cfg[slot][idx];
                3:       word = 32'(m_evt_en[slot]);
                default: word = '0;
            endcase
        end else if (slot == `UDMA_CTRL_SLOT) begin
            case (idx)
                0:       word = 32'(m_cg);
                1:       word = {m_sel[3], m_sel[2], m_sel[1], m_sel[0]};
                default: word = '0;
            endcase
        end
        return word;
    endfunction

    task automatic model_write(int slot, int idx, udma_cfg_pkg::cfg_word_t data);
        if (slot < NP && m_cg[slot]) begin
            case (idx)
                0, 1, 2: m_cfg[slot][idx] = data;
                3:       m_evt_en[slot] = data[NT-1:0];
                default: ;
            endcase
        end else if (slot == `UDMA_CTRL_SLOT) begin
            case (idx)
                0:       m_cg = data[NP-1:0];
                1:       {m_sel[3], m_sel[2], m_sel[1], m_sel[0]} = data;
                default: ;
            endcase
        end
    endtask

    // events_o expected two cycles after a strobe
    function automatic logic [EW-1:0] predict_events(logic valid, udma_evt_pkg::evt_byte_t code);
        udma_evt_pkg::udma_evt_t trig;
        logic [EW-1:0]           vec;
        vec = '0;
        for (int k = 0; k < NT; k++) begin
            trig[k] = valid && (code == m_sel[k]);
        end
        for (int p = 0; p < NP; p++) begin
            vec[p*NT +: NT] = m_cg[p] ? (trig & m_evt_en[p]) : '0;
        end
        return vec;
    endfunction

    task automatic check_value(string name, logic [EW-1:0] got, logic [EW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic apb_access(int slot, int idx, logic write, udma_cfg_pkg::cfg_word_t wdata);
        int                      cycles;
        logic                    err_exp;
        udma_cfg_pkg::cfg_word_t rdata_exp;
        err_exp   = !(slot < NP || slot == `UDMA_CTRL_SLOT);
        rdata_exp = model_read(slot, idx);
        apb_paddr   = {udma_cfg_pkg::slot_idx_t'(slot), udma_cfg_pkg::reg_idx_t'(idx), 2'b00};
        apb_pwrite  = write;
        apb_pwdata  = wdata;
        apb_psel    = 1'b1;
        apb_penable = 1'b0;
        @(posedge sys_clk);
        #1;
        apb_penable = 1'b1;
        // cycle 1 was setup
        cycles = 2;
        while (!apb_pready && cycles < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            #1;
            cycles++;
        end
        if (!apb_pready) begin
            $display("no pready for slot %0d register %0d after %0d cycles", slot, idx, cycles);
            $display("errors: %0d, checks: %0d", errors + 1, checks);
            $display("Regression failed");
            $finish;
        end else begin
            check_value("apb_pready cycle", cycles, 3);
            check_value("apb_pslverr", apb_pslverr, err_exp);
            if (err_exp || !write) begin
                check_value("apb_prdata", apb_prdata, rdata_exp);
            end
            if (write) begin
                model_write(slot, idx, wdata);
            end
            @(posedge sys_clk);
            #1;
            apb_psel    = 1'b0;
            apb_penable = 1'b0;
        end
    endtask

    task automatic read_slot(int slot);
        for (int r = 0; r < 32; r++) begin
            apb_access(slot, r, 1'b0, '0);
        end
    endtask

    task automatic random_writes(int n, int max_idx);
        int          slot;
        int          idx;
        logic [31:0] data;
        for (int i = 0; i < n; i++) begin
            slot = next_rand() % NP;
            idx  = next_rand() % max_idx;
            data = next_rand();
            apb_access(slot, idx, 1'b1, data);
        end
    endtask

    task automatic run_events(int n);
        logic [EW-1:0]           exp_d1;
        logic [EW-1:0]           exp_d2;
        logic [31:0]             r;
        logic                    valid;
        udma_evt_pkg::evt_byte_t code;
        exp_d1 = '0;
        exp_d2 = '0;
        // two idle cycles at the end drain the pipeline
        for (int i = 0; i < n + 2; i++) begin
            r     = next_rand();
            valid = (i < n) && r[0];
            code  = r[1] ? m_sel[r[3:2]] : r[15:8];
            check_value("events_o", events, exp_d2);
            check_value("event_ready_o", event_ready, 1'b1);
            event_valid = valid;
            event_data  = code;
            exp_d2 = exp_d1;
            exp_d1 = predict_events(valid, code);
            @(posedge sys_clk);
            #1;
        end
        event_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] word;
        int          slot;
        reset       = 1'b1;
        apb_paddr   = '0;
        apb_pwdata  = '0;
        apb_pwrite  = 1'b0;
        apb_psel    = 1'b0;
        apb_penable = 1'b0;
        event_valid = 1'b0;
        event_data  = '0;
        m_cfg    = '{default: '0};
        m_evt_en = '{default: '0};
        m_sel    = '{default: '0};
        m_cg     = '0;
        repeat (3) @(posedge sys_clk);
        #1;
        reset = 1'b0;

        // reset state
        check_value("apb_pready", apb_pready, 1'b0);
        check_value("apb_pslverr", apb_pslverr, 1'b0);
        check_value("events_o", events, '0);
        @(posedge sys_clk);
        #1;
        check_value("event_ready_o", event_ready, 1'b1);
        read_slot(`UDMA_CTRL_SLOT);
        for (int p = 0; p < NP; p++) begin
            read_slot(p);
        end

        // enabled peripherals, upper gate bits are dropped
        apb_access(`UDMA_CTRL_SLOT, 0, 1'b1, next_rand() | ((32'd1 << NP) - 1));
        // reset values of the banks, visible only with the gates open
        for (int p = 0; p < NP; p++) begin
            read_slot(p);
        end
        random_writes(60, 6);
        for (int p = 0; p < NP; p++) begin
            read_slot(p);
        end

        // at least one gated peripheral, then everything back on
        word = next_rand();
        word[next_rand() % NP] = 1'b0;
        apb_access(`UDMA_CTRL_SLOT, 0, 1'b1, word);
        random_writes(40, 4);
        for (int p = 0; p < NP; p++) begin
            read_slot(p);
        end
        apb_access(`UDMA_CTRL_SLOT, 0, 1'b1, (32'd1 << NP) - 1);
        for (int p = 0; p < NP; p++) begin
            read_slot(p);
        end

        // unmapped slots
        for (int i = 0; i < 30; i++) begin
            slot = NP + next_rand() % (`UDMA_CTRL_SLOT - NP);
            word = next_rand();
            apb_access(slot, word[12:8], word[0], next_rand());
        end
        for (int p = 0; p < NP; p++) begin
            read_slot(p);
        end
        apb_access(`UDMA_CTRL_SLOT, 1, 1'b1, next_rand());
        read_slot(`UDMA_CTRL_SLOT);

        // events with a duplicated select byte
        for (int p = 0; p < NP; p++) begin
            apb_access(p, 3, 1'b1, next_rand());
        end
        word = next_rand();
        word[15:8] = word[7:0];
        apb_access(`UDMA_CTRL_SLOT, 1, 1'b1, word);
        word = next_rand();
        word[next_rand() % NP] = 1'b0;
        apb_access(`UDMA_CTRL_SLOT, 0, 1'b1, word);
        run_events(300);
        apb_access(`UDMA_CTRL_SLOT, 1, 1'b1, next_rand());
        apb_access(`UDMA_CTRL_SLOT, 0, 1'b1, (32'd1 << NP) - 1);
        run_events(200);

        errors += dut.u_assert.assert_errors;
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verif/udma_subsystem_assert.sv ====
// ==================================================
// apb and event assertions, bound to udma_subsystem
// ==================================================

`timescale 1ns/1ps

`include "udma_params.svh"

module udma_subsystem_assert (
    input logic                                            sys_clk_i,
    input logic                                            reset_i,
    input logic                                            apb_psel_i,
    input logic                                            apb_penable_i,
    input logic                                            apb_pready_i,
    input logic                                            apb_pslverr_i,
    input udma_cfg_pkg::cfg_word_t                         apb_prdata_i,
    input udma_evt_pkg::udma_evt_t [`UDMA_N_EVT_SLOTS-1:0] events_i,
    input logic                    [`UDMA_N_PERIPHS-1:0]   cfg_valid_i,
    input logic                                            ctrl_valid_i,
    input logic                                            cfg_err_i
);

    // failure tally
    int unsigned assert_errors = 0;

    pready_in_access: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        apb_pready_i |-> apb_psel_i && apb_penable_i)
        else begin
            $error("pready outside an apb access phase");
            assert_errors++;
        end

    // an error response carries no read data
    pslverr_with_pready: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        apb_pslverr_i |-> apb_pready_i && (apb_prdata_i == '0))
        else begin
            $error("pslverr without pready or with nonzero prdata");
            assert_errors++;
        end

    // slots without a peripheral
    unused_slots_quiet: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        events_i[`UDMA_N_EVT_SLOTS-1:`UDMA_N_PERIPHS] == '0)
        else begin
            $error("event pulse in an unused slot");
            assert_errors++;
        end

    decode_onehot: assert property (@(posedge sys_clk_i) disable iff (reset_i)
        $onehot0({cfg_valid_i, ctrl_valid_i, cfg_err_i}))
        else begin
            $error("more than one decode strobe active");
            assert_errors++;
        end

endmodule

bind udma_subsystem udma_subsystem_assert u_assert (
    .sys_clk_i     ( sys_clk_i     ),
    .reset_i       ( reset_i       ),
    .apb_psel_i    ( apb_psel_i    ),
    .apb_penable_i ( apb_penable_i ),
    .apb_pready_i  ( apb_pready_o  ),
    .apb_pslverr_i ( apb_pslverr_o ),
    .apb_prdata_i  ( apb_prdata_o  ),
    .events_i      ( events_o      ),
    .cfg_valid_i   ( cfg_valid     ),
    .ctrl_valid_i  ( ctrl_valid    ),
    .cfg_err_i     ( cfg_err       )
);

// ==== source/udma_subsystem.sv ====
// ==================================================
// udma subsystem top: apb decode, control, peripheral
// banks, apb response and events_o assembly
// ==================================================

`timescale 1ns/1ps

`include "udma_params.svh"

module udma_subsystem (
    input  logic                                                sys_clk_i,
    input  logic                                                reset_i,
    input  logic                    [`UDMA_APB_ADDR_WIDTH-1:0]  apb_paddr_i,
    input  udma_cfg_pkg::cfg_word_t                             apb_pwdata_i,
    input  logic                                                apb_pwrite_i,
    input  logic                                                apb_psel_i,
    input  logic                                                apb_penable_i,
    output udma_cfg_pkg::cfg_word_t                             apb_prdata_o,
    output logic                                                apb_pready_o,
    output logic                                                apb_pslverr_o,
    input  logic                                                event_valid_i,
    input  udma_evt_pkg::evt_byte_t                             event_data_i,
    output logic                                                event_ready_o,
    output udma_evt_pkg::udma_evt_t [`UDMA_N_EVT_SLOTS-1:0]     events_o
);

    // configuration bus
    logic                    [`UDMA_N_PERIPHS-1:0] cfg_valid;
    logic                                          ctrl_valid;
    logic                                          cfg_err;
    udma_cfg_pkg::reg_idx_t                        cfg_reg;
    logic                                          cfg_rwn;
    udma_cfg_pkg::cfg_word_t                       cfg_wdata;

    // target answers
    logic                    [`UDMA_N_PERIPHS-1:0] periph_ready;
    udma_cfg_pkg::cfg_word_t [`UDMA_N_PERIPHS-1:0] periph_rdata;
    logic                                          ctrl_ready;
    udma_cfg_pkg::cfg_word_t                       ctrl_rdata;

    logic                    [`UDMA_N_PERIPHS-1:0] clk_en;
    udma_evt_pkg::udma_evt_t                       trigger;
    udma_evt_pkg::udma_evt_t [`UDMA_N_PERIPHS-1:0] periph_events;

    udma_cfg_decode i_cfg_decode (
        .sys_clk_i     ( sys_clk_i     ),
        .reset_i       ( reset_i       ),
        .apb_paddr_i   ( apb_paddr_i   ),
        .apb_pwdata_i  ( apb_pwdata_i  ),
        .apb_pwrite_i  ( apb_pwrite_i  ),
        .apb_psel_i    ( apb_psel_i    ),
        .apb_penable_i ( apb_penable_i ),
        .cfg_valid_o   ( cfg_valid     ),
        .ctrl_valid_o  ( ctrl_valid    ),
        .cfg_err_o     ( cfg_err       ),
        .cfg_reg_o     ( cfg_reg       ),
        .cfg_rwn_o     ( cfg_rwn       ),
        .cfg_wdata_o   ( cfg_wdata     )
    );

    udma_ctrl i_ctrl (
        .sys_clk_i     ( sys_clk_i     ),
        .reset_i       ( reset_i       ),
        .cfg_valid_i   ( ctrl_valid    ),
        .cfg_reg_i     ( cfg_reg       ),
        .cfg_rwn_i     ( cfg_rwn       ),
        .cfg_wdata_i   ( cfg_wdata     ),
        .cfg_ready_o   ( ctrl_ready    ),
        .cfg_rdata_o   ( ctrl_rdata    ),
        .event_valid_i ( event_valid_i ),
        .event_data_i  ( event_data_i  ),
        .event_ready_o ( event_ready_o ),
        .clk_en_o      ( clk_en        ),
        .trigger_o     ( trigger       )
    );

    // one register bank per peripheral slot
    for (genvar p = 0; p < `UDMA_N_PERIPHS; p++) begin : g_periph
        udma_periph_cfg i_periph_cfg (
            .sys_clk_i   ( sys_clk_i        ),
            .reset_i     ( reset_i          ),
            .clk_en_i    ( clk_en[p]        ),
            .cfg_valid_i ( cfg_valid[p]     ),
            .cfg_reg_i   ( cfg_reg          ),
            .cfg_rwn_i   ( cfg_rwn          ),
            .cfg_wdata_i ( cfg_wdata        ),
            .cfg_ready_o ( periph_ready[p]  ),
            .cfg_rdata_o ( periph_rdata[p]  ),
            .events_i    ( trigger          ),
            .events_o    ( periph_events[p] )
        );
        assign events_o[p] = periph_events[p];
    end

    // slots without a peripheral stay quiet
    for (genvar s = `UDMA_N_PERIPHS; s < `UDMA_N_EVT_SLOTS; s++) begin : g_evt_pad
        assign events_o[s] = '0;
    end

    udma_cfg_resp i_cfg_resp (
        .sys_clk_i      ( sys_clk_i     ),
        .reset_i        ( reset_i       ),
        .periph_ready_i ( periph_ready  ),
        .periph_rdata_i ( periph_rdata  ),
        .ctrl_ready_i   ( ctrl_ready    ),
        .ctrl_rdata_i   ( ctrl_rdata    ),
        .cfg_err_i      ( cfg_err       ),
        .apb_prdata_o   ( apb_prdata_o  ),
        .apb_pready_o   ( apb_pready_o  ),
        .apb_pslverr_o  ( apb_pslverr_o )
    );

endmodule

// ==== source/udma_cfg_resp.sv ====
// ==================================================
// apb ready, read data and error return
// ==================================================

`timescale 1ns/1ps

`include "udma_params.svh"

module udma_cfg_resp (
    input  logic                                                sys_clk_i,
    input  logic                                                reset_i,
    input  logic                    [`UDMA_N_PERIPHS-1:0]       periph_ready_i,
    input  udma_cfg_pkg::cfg_word_t [`UDMA_N_PERIPHS-1:0]       periph_rdata_i,
    input  logic                                                ctrl_ready_i,
    input  udma_cfg_pkg::cfg_word_t                             ctrl_rdata_i,
    input  logic                                                cfg_err_i,
    output udma_cfg_pkg::cfg_word_t                             apb_prdata_o,
    output logic                                                apb_pready_o,
    output logic                                                apb_pslverr_o
);

    logic                    err_q;
    udma_cfg_pkg::cfg_word_t rdata_sel;

    // error has no target, so it waits one cycle to line up with ready
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= cfg_err_i;
        end
    end

    // and-or select, only the answering target contributes
    always_comb begin
        rdata_sel = '0;
        for (int p = 0; p < `UDMA_N_PERIPHS; p++) begin
            if (periph_ready_i[p]) begin
                rdata_sel = rdata_sel | periph_rdata_i[p];
            end
        end
        if (ctrl_ready_i) begin
            rdata_sel = rdata_sel | ctrl_rdata_i;
        end
    end

    assign apb_pready_o  = (|periph_ready_i) | ctrl_ready_i | err_q;
    assign apb_pslverr_o = err_q;
    assign apb_prdata_o  = rdata_sel;

endmodule

// ==== source/udma_periph_cfg.sv ====
// ==================================================
// register bank and event output of one peripheral
// ==================================================

`timescale 1ns/1ps

module udma_periph_cfg (
    input  logic                    sys_clk_i,
    input  logic                    reset_i,
    input  logic                    clk_en_i,
    input  logic                    cfg_valid_i,
    input  udma_cfg_pkg::reg_idx_t  cfg_reg_i,
    input  logic                    cfg_rwn_i,
    input  udma_cfg_pkg::cfg_word_t cfg_wdata_i,
    output logic                    cfg_ready_o,
    output udma_cfg_pkg::cfg_word_t cfg_rdata_o,
    input  udma_evt_pkg::udma_evt_t events_i,
    output udma_evt_pkg::udma_evt_t events_o
);

    udma_cfg_pkg::cfg_word_t cfg0_q;
    udma_cfg_pkg::cfg_word_t cfg1_q;
    udma_cfg_pkg::cfg_word_t cfg2_q;
    udma_evt_pkg::udma_evt_t evt_en_q;
    udma_cfg_pkg::cfg_word_t rdata_mux;
    logic                    wr_en;

    // a gated peripheral still answers but keeps its state
    assign wr_en = cfg_valid_i & ~cfg_rwn_i & clk_en_i;

    always_comb begin
        case (cfg_reg_i)
            udma_cfg_pkg::PERIPH_REG_CFG0:   rdata_mux = cfg0_q;
            udma_cfg_pkg::PERIPH_REG_CFG1:   rdata_mux = cfg1_q;
            udma_cfg_pkg::PERIPH_REG_CFG2:   rdata_mux = cfg2_q;
            udma_cfg_pkg::PERIPH_REG_EVT_EN: rdata_mux = udma_cfg_pkg::cfg_word_t'(evt_en_q);
            default:                         rdata_mux = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            cfg0_q      <= '0;
            cfg1_q      <= '0;
            cfg2_q      <= '0;
            evt_en_q    <= '0;
            cfg_ready_o <= 1'b0;
            events_o    <= '0;
        end else begin
            cfg_ready_o <= cfg_valid_i;
            // triggers pass only when enabled both globally and locally
            events_o    <= events_i & evt_en_q & {$bits(events_i){clk_en_i}};
            if (wr_en) begin
                case (cfg_reg_i)
                    udma_cfg_pkg::PERIPH_REG_CFG0:   cfg0_q   <= cfg_wdata_i;
                    udma_cfg_pkg::PERIPH_REG_CFG1:   cfg1_q   <= cfg_wdata_i;
                    udma_cfg_pkg::PERIPH_REG_CFG2:   cfg2_q   <= cfg_wdata_i;
                    udma_cfg_pkg::PERIPH_REG_EVT_EN: evt_en_q <= cfg_wdata_i[$bits(evt_en_q)-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (cfg_valid_i) begin
            cfg_rdata_o <= clk_en_i ? rdata_mux : '0;
        end
    end

endmodule

// ==== source/udma_ctrl.sv ====
// ==================================================
// core control registers and trigger event matching
// ==================================================

`timescale 1ns/1ps

`include "udma_params.svh"

module udma_ctrl (
    input  logic                       sys_clk_i,
    input  logic                       reset_i,
    input  logic                       cfg_valid_i,
    input  udma_cfg_pkg::reg_idx_t     cfg_reg_i,
    input  logic                       cfg_rwn_i,
    input  udma_cfg_pkg::cfg_word_t    cfg_wdata_i,
    output logic                       cfg_ready_o,
    output udma_cfg_pkg::cfg_word_t    cfg_rdata_o,
    input  logic                       event_valid_i,
    input  udma_evt_pkg::evt_byte_t    event_data_i,
    output logic                       event_ready_o,
    output logic [`UDMA_N_PERIPHS-1:0] clk_en_o,
    output udma_evt_pkg::udma_evt_t    trigger_o
);

    logic [`UDMA_N_PERIPHS-1:0] cg_q;
    udma_evt_pkg::evt_sel_t     sel_q;
    udma_cfg_pkg::cfg_word_t    rdata_mux;
    udma_evt_pkg::udma_evt_t    match;
    logic                       evt_hs;

    assign clk_en_o = cg_q;
    assign evt_hs   = event_valid_i & event_ready_o;

    // compare the accepted byte against every select
    always_comb begin
        for (int k = 0; k < `UDMA_N_TRIGGERS; k++) begin
            match[k] = evt_hs && (event_data_i == sel_q[k]);
        end
    end

    always_comb begin
        case (cfg_reg_i)
            udma_cfg_pkg::CTRL_REG_CG:      rdata_mux = udma_cfg_pkg::cfg_word_t'(cg_q);
            udma_cfg_pkg::CTRL_REG_EVT_SEL: rdata_mux = udma_cfg_pkg::cfg_word_t'(sel_q);
            default:                        rdata_mux = '0;
        endcase
    end

    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            cg_q          <= '0;
            sel_q         <= '0;
            cfg_ready_o   <= 1'b0;
            event_ready_o <= 1'b0;
            trigger_o     <= '0;
        end else begin
            cfg_ready_o   <= cfg_valid_i;
            // always able to take an event once out of reset
            event_ready_o <= 1'b1;
            trigger_o     <= match;
            if (cfg_valid_i && !cfg_rwn_i) begin
                case (cfg_reg_i)
                    udma_cfg_pkg::CTRL_REG_CG:      cg_q  <= cfg_wdata_i[`UDMA_N_PERIPHS-1:0];
                    udma_cfg_pkg::CTRL_REG_EVT_SEL: sel_q <= udma_evt_pkg::evt_sel_t'(cfg_wdata_i);
                    default: ;
                endcase
            end
        end
    end

    // read word, sampled with the request
    always_ff @(posedge sys_clk_i) begin
        if (cfg_valid_i) begin
            cfg_rdata_o <= rdata_mux;
        end
    end

endmodule

// ==== source/udma_cfg_decode.sv ====
// ==================================================
// apb setup decode onto the configuration bus
// ==================================================

`timescale 1ns/1ps

`include "udma_params.svh"

module udma_cfg_decode (
    input  logic                            sys_clk_i,
    input  logic                            reset_i,
    input  logic [`UDMA_APB_ADDR_WIDTH-1:0] apb_paddr_i,
    input  udma_cfg_pkg::cfg_word_t         apb_pwdata_i,
    input  logic                            apb_pwrite_i,
    input  logic                            apb_psel_i,
    input  logic                            apb_penable_i,
    output logic [`UDMA_N_PERIPHS-1:0]      cfg_valid_o,
    output logic                            ctrl_valid_o,
    output logic                            cfg_err_o,
    output udma_cfg_pkg::reg_idx_t          cfg_reg_o,
    output logic                            cfg_rwn_o,
    output udma_cfg_pkg::cfg_word_t         cfg_wdata_o
);

    udma_cfg_pkg::slot_idx_t    slot;
    udma_cfg_pkg::reg_idx_t     reg_idx;
    logic                       setup;
    logic [`UDMA_N_PERIPHS-1:0] periph_hit;
    logic                       ctrl_hit;

    // setup phase only, access phase is left to the targets
    assign setup   = apb_psel_i & ~apb_penable_i;
    assign slot    = apb_paddr_i[`UDMA_APB_ADDR_WIDTH-1:udma_cfg_pkg::SLOT_LSB];
    assign reg_idx = apb_paddr_i[udma_cfg_pkg::SLOT_LSB-1:udma_cfg_pkg::REG_LSB];

    always_comb begin
        for (int p = 0; p < `UDMA_N_PERIPHS; p++) begin
            periph_hit[p] = (slot == udma_cfg_pkg::slot_idx_t'(p));
        end
    end

    assign ctrl_hit = (slot == udma_cfg_pkg::slot_idx_t'(`UDMA_CTRL_SLOT));

    // one-cycle strobes, at most one of them per transfer
    always_ff @(posedge sys_clk_i) begin
        if (reset_i) begin
            cfg_valid_o  <= '0;
            ctrl_valid_o <= 1'b0;
            cfg_err_o    <= 1'b0;
        end else begin
            cfg_valid_o  <= setup ? periph_hit : '0;
            ctrl_valid_o <= setup & ctrl_hit;
            // unmapped slot
            cfg_err_o    <= setup & ~ctrl_hit & ~(|periph_hit);
        end
    end

    // payload travels alongside the strobe
    always_ff @(posedge sys_clk_i) begin
        if (setup) begin
            cfg_reg_o   <= reg_idx;
            cfg_rwn_o   <= ~apb_pwrite_i;
            cfg_wdata_o <= apb_pwdata_i;
        end
    end

endmodule

// ==== source/udma_evt_pkg.sv ====
// ==================================================
// event vector and event-select byte types
// ==================================================

`include "udma_params.svh"

package udma_evt_pkg;

    // one bit per trigger in every slot
    typedef logic [`UDMA_N_TRIGGERS-1:0] udma_evt_t;

    // code carried on the event strobe
    typedef logic [7:0] evt_byte_t;

    // select bytes packed into one control word, byte k at bits 8k+7:8k
    typedef evt_byte_t [`UDMA_N_TRIGGERS-1:0] evt_sel_t;

endpackage

// ==== source/udma_cfg_pkg.sv ====
// ==================================================
// configuration space types, slot and register indexes
// ==================================================

`include "udma_params.svh"

package udma_cfg_pkg;

    // address split: slot above bit 7, word register above bit 2
    localparam int unsigned SLOT_LSB = 7;
    localparam int unsigned REG_LSB  = 2;

    typedef logic [`UDMA_APB_ADDR_WIDTH-SLOT_LSB-1:0] slot_idx_t;
    typedef logic [SLOT_LSB-REG_LSB-1:0]              reg_idx_t;
    typedef logic [31:0]                              cfg_word_t;

    // peripheral slot registers
    localparam reg_idx_t PERIPH_REG_CFG0   = 5'd0;
    localparam reg_idx_t PERIPH_REG_CFG1   = 5'd1;
    localparam reg_idx_t PERIPH_REG_CFG2   = 5'd2;
    localparam reg_idx_t PERIPH_REG_EVT_EN = 5'd3;

    // control slot registers
    localparam reg_idx_t CTRL_REG_CG      = 5'd0;
    localparam reg_idx_t CTRL_REG_EVT_SEL = 5'd1;

endpackage

// ==== source/udma_params.svh ====
// ==================================================
// widths, counts and address map of the udma subsystem
// ==================================================

`ifndef UDMA_PARAMS_SVH
`define UDMA_PARAMS_SVH

// apb slave covers 4KB
`define UDMA_APB_ADDR_WIDTH 12

// peripheral slots in use
`define UDMA_N_PERIPHS 4

// core control registers live in the last slot
`define UDMA_CTRL_SLOT 31

// trigger events and event-select bytes
`define UDMA_N_TRIGGERS 4

// slots carried by events_o
`define UDMA_N_EVT_SLOTS 32

`endif
